// File: backoff_consts.svh
`ifndef BACKOFF_CONSTS_SVH
`define BACKOFF_CONSTS_SVH

// Access categories, AC3 highest priority
`define BACKOFF_NUM_AC     4

// Contention window exponent width
`define BACKOFF_CW_W       4

// Exponent ceiling, CW = 1023 slots
`define BACKOFF_CW_LIMIT   10

`define BACKOFF_CNT_W      16   // Backoff slot counter
`define BACKOFF_PRNG_W     16   // Random word

// LFSR start value, must be nonzero
`define BACKOFF_PRNG_SEED  16'hACE1

`endif

// File: backoffPkg.sv
`include "backoff_consts.svh"

package backoffPkg;

  // Access category index
  typedef logic [$clog2(`BACKOFF_NUM_AC)-1:0] acIdxT;

  // One bit per access category
  typedef logic [`BACKOFF_NUM_AC-1:0] acVecT;

  // Contention window exponent, CW = 2^exp - 1
  typedef logic [`BACKOFF_CW_W-1:0] cwExpT;

  // Static window bounds of one category
  typedef struct packed {
    cwExpT cwMin;   // Exponent after success or enable
    cwExpT cwMax;   // Growth ceiling
  } acCwCfgT;

  // Window bounds of all categories, AC0 in low byte
  typedef acCwCfgT [`BACKOFF_NUM_AC-1:0] cwCfgT;

  // Live exponents of all categories
  typedef cwExpT [`BACKOFF_NUM_AC-1:0] cwStateT;

  // Outcome strobes for the active category
  typedef struct packed {
    logic txSuccessful_p;
    logic txFailed_p;
  } txOutcomeT;

  // Window and counter commands from selector to bank
  typedef struct packed {
    acVecT growVec;    // Double the window
    acVecT resetVec;   // Back to cwMin
    acVecT loadVec;    // Redraw the counter
  } cwUpdateT;

endpackage

// File: backoffPrng.sv
`timescale 1ns/1ps
`include "backoff_consts.svh"

module backoffPrng
(
  input  logic                        macCoreClk,
  input  logic                        macCoreClkHardRst_n,
  output logic [`BACKOFF_PRNG_W-1:0]  pseudoRandomNumber
);

  logic feedback;   // Bit shifted in at the bottom

  ////////////////////////////////////////
  // Fibonacci LFSR
  ////////////////////////////////////////

  // Maximal-length polynomial x^16 + x^14 + x^13 + x^11 + 1
  assign feedback = pseudoRandomNumber[15] ^
                    pseudoRandomNumber[13] ^
                    pseudoRandomNumber[12] ^
                    pseudoRandomNumber[10];

  // One step per clock
  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      pseudoRandomNumber <= `BACKOFF_PRNG_SEED;
    end
    else
    begin
      pseudoRandomNumber <= {pseudoRandomNumber[`BACKOFF_PRNG_W-2:0], feedback};
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // All-zero lockup never reached from the seed
  lfsrNeverZero: assert property (
    @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    pseudoRandomNumber != '0);

endmodule

// File: backoffCntBank.sv
`timescale 1ns/1ps
`include "backoff_consts.svh"

module backoffCntBank
(
  input  logic                        macCoreClk,
  input  logic                        macCoreClkHardRst_n,
  input  logic                        backoffEnable,        // Engine active
  input  backoffPkg::acVecT           acHasData,            // Queue not empty
  input  logic                        tickSlot_p,           // Slot boundary
  input  logic                        channelBusy,          // CCA or NAV busy
  input  logic                        mediumHeld,           // Grant pending outcome
  input  logic [`BACKOFF_PRNG_W-1:0]  pseudoRandomNumber,
  input  backoffPkg::cwCfgT           cwCfg,
  input  backoffPkg::cwUpdateT        cwUpdate,
  output backoffPkg::acVecT           expiredVec,           // Counter zero with data
  output backoffPkg::cwStateT         currentCW
);

  import backoffPkg::*;

  localparam cwExpT CwLimit = `BACKOFF_CW_LIMIT;

  logic   backoffEnableDly;   // Enable one cycle late
  acVecT  acHasDataDly;       // Has-data one cycle late
  logic   enableRise;         // Core becomes active
  acVecT  hasDataRise;        // Queue becomes non-empty
  logic   slotCount;          // Shared decrement qualifier

  ////////////////////////////////////////
  // Edge detection
  ////////////////////////////////////////

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      backoffEnableDly <= 1'b0;
      acHasDataDly     <= '0;
    end
    else
    begin
      backoffEnableDly <= backoffEnable;
      acHasDataDly     <= acHasData;
    end
  end

  assign enableRise  = backoffEnable & ~backoffEnableDly;
  assign hasDataRise = acHasData & ~acHasDataDly;

  // Idle slot on a free medium
  assign slotCount = tickSlot_p & backoffEnable & ~channelBusy & ~mediumHeld;

  ////////////////////////////////////////
  // Per-category window and counter
  ////////////////////////////////////////

  for (genvar ac = 0; ac < `BACKOFF_NUM_AC; ac++)
  begin : gAc
    cwExpT                      cwCur;        // Current exponent
    cwExpT                      cwFloor;      // cwMin within limit
    cwExpT                      cwCeil;       // cwMax within limit
    cwExpT                      cwNext;       // Exponent after this edge
    logic                       cntLoad;      // Redraw request
    logic [`BACKOFF_CNT_W-1:0]  cntMask;      // Low cwNext bits set
    logic [`BACKOFF_CNT_W-1:0]  backoffCnt;   // Slots left

    assign cwFloor = (cwCfg[ac].cwMin > CwLimit) ? CwLimit : cwCfg[ac].cwMin;
    assign cwCeil  = (cwCfg[ac].cwMax > CwLimit) ? CwLimit : cwCfg[ac].cwMax;

    // Enable edge wins over any selector command
    always_comb
    begin
      if (enableRise || cwUpdate.resetVec[ac])
        cwNext = cwFloor;
      else if (cwUpdate.growVec[ac])
        cwNext = (cwCur >= cwCeil) ? cwCeil : cwCur + 1'b1;
      else
        cwNext = cwCur;
    end

    // Draw uses the updated exponent
    assign cntMask = ~({`BACKOFF_CNT_W{1'b1}} << cwNext);
    assign cntLoad = enableRise | hasDataRise[ac] | cwUpdate.loadVec[ac];

    always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
    begin
      if (!macCoreClkHardRst_n)
      begin
        cwCur      <= '0;
        backoffCnt <= '0;
      end
      else
      begin
        cwCur <= cwNext;
        if (cntLoad)
          backoffCnt <= pseudoRandomNumber[`BACKOFF_CNT_W-1:0] & cntMask;
        else if (slotCount && (backoffCnt != '0))
          backoffCnt <= backoffCnt - 1'b1;   // Holds at zero
      end
    end

    assign currentCW[ac]  = cwCur;
    assign expiredVec[ac] = (backoffCnt == '0) & acHasData[ac];

    // Grow and reset both stay inside the legal range
    cwWithinLimit: assert property (
      @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
      cwCur <= CwLimit);
  end

endmodule

// File: backoffAcSel.sv
`timescale 1ns/1ps
`include "backoff_consts.svh"

module backoffAcSel
(
  input  logic                   macCoreClk,
  input  logic                   macCoreClkHardRst_n,
  input  logic                   backoffEnable,
  input  logic                   tickSlot_p,
  input  logic                   channelBusy,
  input  backoffPkg::acVecT      expiredVec,
  input  backoffPkg::txOutcomeT  txOutcome,        // Result for activeAC
  output backoffPkg::acVecT      trigTxAC,         // One-hot grant pulse
  output backoffPkg::acVecT      internalColl_p,   // Collision losers
  output backoffPkg::acIdxT      activeAC,         // Last winner
  output logic                   mediumHeld,       // Waiting for outcome
  output backoffPkg::cwUpdateT   cwUpdate
);

  import backoffPkg::*;

  logic   grantReq;    // Arbitrate this cycle
  acIdxT  winnerIdx;   // Highest expired category
  acVecT  winnerVec;
  acVecT  loserVec;
  acVecT  activeVec;   // activeAC as a vector
  logic   txDone;      // Outcome while medium held

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  assign grantReq = tickSlot_p & backoffEnable & ~channelBusy & ~mediumHeld & (|expiredVec);

  // Later bits overwrite, so AC3 wins
  always_comb
  begin
    winnerIdx = '0;
    for (int ac = 0; ac < `BACKOFF_NUM_AC; ac++)
    begin
      if (expiredVec[ac])
        winnerIdx = acIdxT'(ac);
    end
  end

  assign winnerVec = acVecT'(1) << winnerIdx;
  assign loserVec  = expiredVec & ~winnerVec;   // Internal collision set

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      trigTxAC       <= '0;
      internalColl_p <= '0;
      activeAC       <= '0;
      mediumHeld     <= 1'b0;
    end
    else
    begin
      trigTxAC       <= grantReq ? winnerVec : '0;
      internalColl_p <= grantReq ? loserVec : '0;
      if (grantReq)
        activeAC <= winnerIdx;
      // Held from grant until the outcome strobe
      if (grantReq)
        mediumHeld <= 1'b1;
      else if (txDone)
        mediumHeld <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Window update routing
  ////////////////////////////////////////

  assign txDone    = mediumHeld & (txOutcome.txSuccessful_p | txOutcome.txFailed_p);
  assign activeVec = acVecT'(1) << activeAC;

  // Same cycle as the outcome, so the winner reloads before mediumHeld drops
  // Losers grow with the grant pulse, success beats failure
  always_comb
  begin
    cwUpdate.growVec  = internalColl_p;
    cwUpdate.resetVec = '0;
    cwUpdate.loadVec  = internalColl_p;
    if (txDone)
    begin
      cwUpdate.loadVec = internalColl_p | activeVec;
      if (txOutcome.txSuccessful_p)
        cwUpdate.resetVec = activeVec;
      else
        cwUpdate.growVec = internalColl_p | activeVec;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  grantOneHot: assert property (
    @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    $onehot0(trigTxAC));

  // Winner never listed as a loser
  grantNotCollided: assert property (
    @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    (trigTxAC & internalColl_p) == '0);

  grantSinglePulse: assert property (
    @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    |trigTxAC |=> trigTxAC == '0);

endmodule

// File: backoffTop.sv
`timescale 1ns/1ps
`include "backoff_consts.svh"

module backoffTop
(
  input  logic                   macCoreClk,
  input  logic                   macCoreClkHardRst_n,
  input  logic                   backoffEnable,    // Core active
  input  backoffPkg::acVecT      acHasData,        // Queue status levels
  input  logic                   tickSlot_p,       // Slot boundary strobe
  input  logic                   channelBusy,
  input  backoffPkg::txOutcomeT  txOutcome,
  input  backoffPkg::cwCfgT      cwCfg,            // Static window bounds
  output backoffPkg::acVecT      trigTxAC,
  output backoffPkg::acVecT      internalColl_p,
  output backoffPkg::acIdxT      activeAC,
  output backoffPkg::cwStateT    currentCW
);

  import backoffPkg::*;

  logic [`BACKOFF_PRNG_W-1:0]  pseudoRandomNumber;
  acVecT                       expiredVec;   // Bank to selector
  cwUpdateT                    cwUpdate;     // Selector to bank
  logic                        mediumHeld;   // Freezes the counters

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  backoffPrng U_backoffPrng (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .pseudoRandomNumber  (pseudoRandomNumber)
  );

  ////////////////////////////////////////
  // Counters and windows
  ////////////////////////////////////////

  backoffCntBank U_backoffCntBank (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .backoffEnable       (backoffEnable),
    .acHasData           (acHasData),
    .tickSlot_p          (tickSlot_p),
    .channelBusy         (channelBusy),
    .mediumHeld          (mediumHeld),
    .pseudoRandomNumber  (pseudoRandomNumber),
    .cwCfg               (cwCfg),
    .cwUpdate            (cwUpdate),
    .expiredVec          (expiredVec),
    .currentCW           (currentCW)
  );

  // Grant, collisions and outcome routing
  backoffAcSel U_backoffAcSel (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .backoffEnable       (backoffEnable),
    .tickSlot_p          (tickSlot_p),
    .channelBusy         (channelBusy),
    .expiredVec          (expiredVec),
    .txOutcome           (txOutcome),
    .trigTxAC            (trigTxAC),
    .internalColl_p      (internalColl_p),
    .activeAC            (activeAC),
    .mediumHeld          (mediumHeld),
    .cwUpdate            (cwUpdate)
  );

endmodule

// File: backoffTb.sv
`timescale 1ns/1ps
`include "backoff_consts.svh"

module backoffTb;

  import backoffPkg::*;

  typedef struct packed {
    acVecT       hasData;   // Queues raised together
    cwCfgT       cfg;       // Same bounds for all categories
    logic        busy;      // Random busy bursts
    logic [3:0]  fails;     // Failures before the closing success
    acIdxT       expWin;
    acVecT       expColl;   // Losers of the first grant
    cwStateT     expCw;     // Windows after the last outcome
  } testRowT;

  localparam int NumRows = 6;

  logic        macCoreClk;
  logic        macCoreClkHardRst_n;
  logic        backoffEnable;
  acVecT       acHasData;
  logic        tickSlot_p;
  logic        channelBusy;
  txOutcomeT   txOutcome;
  cwCfgT       cwCfg;
  acVecT       trigTxAC;
  acVecT       internalColl_p;
  acIdxT       activeAC;
  cwStateT     currentCW;

  testRowT      testTable [NumRows];
  string        rowName [NumRows];
  logic [31:0]  rngState = 32'd4;   // xorshift seed
  int           cycleNum = 0;
  int           cycleLimit = 0;      // Set once the table is known
  int           errorCount = 0;
  logic         busyMode = 1'b0;
  int           busyLeft = 0;        // Cycles until the busy level flips
  logic         grantSeen = 1'b0;
  logic         awaitOutcome = 1'b0; // Grant out and outcome not yet sent
  acVecT        seenTrig;
  acVecT        seenColl;
  acIdxT        seenActive;

  backoffTop i_dut (.*);

  initial
  begin
    macCoreClk = 1'b0;
    forever #5 macCoreClk = ~macCoreClk;   // 100 MHz
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  function automatic cwCfgT makeCfg(input int cwMin, input int cwMax);
    cwCfgT cfg;
    for (int ac = 0; ac < `BACKOFF_NUM_AC; ac++)
      cfg[ac] = {cwExpT'(cwMin), cwExpT'(cwMax)};   // cwMin in high nibble
    return cfg;
  endfunction

  // Exponent never above the global ceiling
  function automatic int clampExp(input int e);
    return (e > `BACKOFF_CW_LIMIT) ? `BACKOFF_CW_LIMIT : e;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
    begin
      errorCount++;
      $display("FAIL t=%0t %s actual=0x%0h expected=0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic reportProblem(input string msg);
    errorCount++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // One clock step with grant capture and the next tick and busy level
  task automatic stepCycle();
    logic busyAtEdge;
    busyAtEdge = channelBusy;   // Level seen by the coming edge
    @(negedge macCoreClk);
    cycleNum++;
    if (trigTxAC != '0)
    begin
      if (busyAtEdge)
        reportProblem("grant issued while the channel was busy");
      if (awaitOutcome)
        reportProblem("second grant while the medium was held");
      grantSeen    = 1'b1;
      awaitOutcome = 1'b1;
      seenTrig     = trigTxAC;
      seenColl     = internalColl_p;
      seenActive   = activeAC;
    end
    else if (internalColl_p != '0)
      reportProblem("collision flagged without a grant");
    tickSlot_p = (cycleNum % 4 == 0);   // Slot every 4 cycles
    if (busyMode)
    begin
      if (busyLeft == 0)
      begin
        channelBusy = ~channelBusy;
        busyLeft    = int'(xorshift() % 13) + 1;
      end
      busyLeft--;
    end
    else
      channelBusy = 1'b0;
  endtask

  // Counter drawn below 2^cw needs at most 2^cw idle ticks to a grant
  task automatic waitGrant(input int tickLimit);
    int idleTicks;
    idleTicks = 0;
    while (!grantSeen && idleTicks < tickLimit)
    begin
      if (tickSlot_p && !channelBusy)
        idleTicks++;
      stepCycle();
    end
    if (!grantSeen)
      reportProblem($sformatf("no grant within %0d idle slot ticks", tickLimit));
  endtask

  ////////////////////////////////////////
  // Stimulus and checking
  ////////////////////////////////////////

  initial
  begin
    testRowT  row;
    int       grants;
    int       rowStart;
    int       testsFailed;
    int       winCw;
    logic     lastGrant;

    // Rows with two queues use cwMin 0 so both expire together
    testTable[0] = {4'b0100, makeCfg(3, 6), 1'b0, 4'd0, 2'd2, 4'b0000, 16'h3333};
    testTable[1] = {4'b1010, makeCfg(0, 2), 1'b0, 4'd0, 2'd3, 4'b0010, 16'h0010};
    testTable[2] = {4'b0001, makeCfg(1, 4), 1'b0, 4'd5, 2'd0, 4'b0000, 16'h1111};
    testTable[3] = {4'b1000, makeCfg(8, 15), 1'b0, 4'd3, 2'd3, 4'b0000, 16'h8888};
    testTable[4] = {4'b0010, makeCfg(2, 4), 1'b1, 4'd2, 2'd1, 4'b0000, 16'h2222};
    testTable[5] = {4'b1100, makeCfg(0, 3), 1'b1, 4'd0, 2'd3, 4'b0100, 16'h0100};
    rowName = '{"single grant", "internal collision", "failure growth",
                "exponent limit", "busy medium", "busy collision"};
    grants = 0;
    for (int r = 0; r < NumRows; r++)
      grants += testTable[r].fails + 1;
    cycleLimit = 64 + grants * ((1 << `BACKOFF_CW_LIMIT) + 8) * 4 * 4;   // x4 margin

    macCoreClkHardRst_n = 1'b0;
    backoffEnable       = 1'b0;
    acHasData           = '0;
    tickSlot_p          = 1'b0;
    channelBusy         = 1'b0;
    txOutcome           = '0;
    cwCfg               = '0;
    testsFailed         = 0;
    repeat (16) @(posedge macCoreClk);
    @(negedge macCoreClk);
    macCoreClkHardRst_n = 1'b1;

    // Reset values
    checkValue("trigTxAC", trigTxAC, '0);
    checkValue("internalColl_p", internalColl_p, '0);
    checkValue("activeAC", activeAC, '0);
    checkValue("currentCW", currentCW, '0);
    $display("Test 0 reset values: %s", (errorCount == 0) ? "PASS" : "FAIL");
    if (errorCount != 0)
      testsFailed++;

    for (int r = 0; r < NumRows; r++)
    begin
      row       = testTable[r];
      rowStart  = errorCount;
      grantSeen = 1'b0;
      cwCfg     = row.cfg;
      busyMode  = row.busy;
      backoffEnable = 1'b1;
      stepCycle();   // Enable edge resets windows
      winCw = clampExp(row.cfg[0].cwMin);
      checkValue("currentCW", currentCW, {`BACKOFF_NUM_AC{cwExpT'(winCw)}});
      acHasData = row.hasData;
      stepCycle();   // Has-data edge redraws
      for (int g = 0; g <= row.fails; g++)
      begin
        waitGrant(1 << winCw);
        checkValue("trigTxAC", seenTrig, acVecT'(1) << row.expWin);
        checkValue("activeAC", seenActive, row.expWin);
        checkValue("internalColl_p", seenColl, (g == 0) ? row.expColl : '0);
        repeat (12) stepCycle();   // Medium held and no grant allowed
        lastGrant = (g == row.fails);
        txOutcome.txSuccessful_p = lastGrant;
        txOutcome.txFailed_p     = !lastGrant;
        stepCycle();
        txOutcome    = '0;
        grantSeen    = 1'b0;
        awaitOutcome = 1'b0;
        if (lastGrant)
          winCw = clampExp(row.cfg[0].cwMin);
        else if (winCw < clampExp(row.cfg[0].cwMax))
          winCw++;   // Grow stops at cwMax
        checkValue("currentCW[win]", currentCW[row.expWin], winCw);
      end
      checkValue("currentCW", currentCW, row.expCw);
      backoffEnable = 1'b0;
      acHasData     = '0;
      busyMode      = 1'b0;
      channelBusy   = 1'b0;
      repeat (2) stepCycle();
      $display("Test %0d %s: %s", r + 1, rowName[r], (errorCount == rowStart) ? "PASS" : "FAIL");
      if (errorCount != rowStart)
        testsFailed++;
    end

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             NumRows + 1, NumRows + 1 - testsFailed, testsFailed, errorCount);
    if (errorCount == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // Watchdog on total cycles
  initial
  begin
    int watchCycles;
    watchCycles = 0;
    wait (cycleLimit > 0);
    while (watchCycles < cycleLimit)
    begin
      @(posedge macCoreClk);
      watchCycles++;
    end
    $display("Timeout: run exceeded %0d cycles", cycleLimit);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: build.f
+incdir+.
backoffPkg.sv
backoffPrng.sv
backoffCntBank.sv
backoffAcSel.sv
backoffTop.sv
backoffTb.sv
